/* verilog/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // encodings match funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_e;

    // word address, the RAM keeps only its low bits
    typedef struct packed {
        logic [29:0] addr;
        logic [3:0]  we;
        logic [31:0] wdata;
        logic        re;
    } dmem_req_t;

endpackage

`default_nettype wire

/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    // supported RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_COPY_B
    } alu_op_e;

    // BR_JUMP covers both JAL and JALR
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_JUMP
    } branch_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4
    } wb_sel_e;

    // all-zero word is a no-op
    typedef struct packed {
        alu_op_e         alu_op;
        logic            a_is_pc;
        logic            b_is_imm;
        branch_e         branch;
        logic            jalr;
        imm_sel_e        imm_sel;
        logic            reg_we;
        wb_sel_e         wb_sel;
        logic            mem_read;
        logic            mem_write;
        mem_pkg::size_e  mem_size;
        logic            load_unsigned;
    } ctrl_t;

    // one retired instruction, data is zero when we is clear
    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        reg_addr_t  rd;
        logic       we;
        xlen_t      data;
    } commit_t;

endpackage

`default_nettype wire

/* verilog/controller.sv */
`timescale 1ns/10ps
`default_nettype none

module controller (
    input  cpu_pkg::xlen_t  inst,
    output cpu_pkg::ctrl_t  ctrl
);

    cpu_pkg::opcode_e  opcode;
    logic [2:0]        funct3;

    assign opcode = cpu_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    // alt selects SUB or SRA
    function automatic cpu_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        cpu_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  op = cpu_pkg::ALU_SLL;
            3'b010:  op = cpu_pkg::ALU_SLT;
            3'b011:  op = cpu_pkg::ALU_SLTU;
            3'b100:  op = cpu_pkg::ALU_XOR;
            3'b101:  op = alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  op = cpu_pkg::ALU_OR;
            default: op = cpu_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl = '0;
        case (opcode)
            cpu_pkg::OPC_LUI: begin
                ctrl.alu_op   = cpu_pkg::ALU_COPY_B;
                ctrl.b_is_imm = 1'b1;
                ctrl.imm_sel  = cpu_pkg::IMM_U;
                ctrl.reg_we   = 1'b1;
            end
            cpu_pkg::OPC_AUIPC: begin
                ctrl.a_is_pc  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.imm_sel  = cpu_pkg::IMM_U;
                ctrl.reg_we   = 1'b1;
            end
            cpu_pkg::OPC_JAL: begin
                ctrl.a_is_pc  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.imm_sel  = cpu_pkg::IMM_J;
                ctrl.branch   = cpu_pkg::BR_JUMP;
                ctrl.reg_we   = 1'b1;
                ctrl.wb_sel   = cpu_pkg::WB_PC4;
            end
            cpu_pkg::OPC_JALR: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.branch   = cpu_pkg::BR_JUMP;
                ctrl.jalr     = 1'b1;
                ctrl.reg_we   = 1'b1;
                ctrl.wb_sel   = cpu_pkg::WB_PC4;
            end
            cpu_pkg::OPC_BRANCH: begin
                // ALU forms pc + imm, comparator decides
                ctrl.a_is_pc  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.imm_sel  = cpu_pkg::IMM_B;
                case (funct3)
                    3'b000:  ctrl.branch = cpu_pkg::BR_EQ;
                    3'b001:  ctrl.branch = cpu_pkg::BR_NE;
                    3'b100:  ctrl.branch = cpu_pkg::BR_LT;
                    3'b101:  ctrl.branch = cpu_pkg::BR_GE;
                    3'b110:  ctrl.branch = cpu_pkg::BR_LTU;
                    3'b111:  ctrl.branch = cpu_pkg::BR_GEU;
                    default: ctrl.branch = cpu_pkg::BR_NONE;
                endcase
            end
            cpu_pkg::OPC_LOAD: begin
                ctrl.b_is_imm      = 1'b1;
                ctrl.reg_we        = 1'b1;
                ctrl.wb_sel        = cpu_pkg::WB_LOAD;
                ctrl.mem_read      = 1'b1;
                ctrl.mem_size      = mem_pkg::size_e'(funct3[1:0]);
                ctrl.load_unsigned = funct3[2];
            end
            cpu_pkg::OPC_STORE: begin
                ctrl.b_is_imm  = 1'b1;
                ctrl.imm_sel   = cpu_pkg::IMM_S;
                ctrl.mem_write = 1'b1;
                ctrl.mem_size  = mem_pkg::size_e'(funct3[1:0]);
            end
            cpu_pkg::OPC_OP_IMM: begin
                // inst[30] only means SRAI here
                ctrl.alu_op   = alu_decode(funct3, inst[30] && (funct3 == 3'b101));
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_we   = 1'b1;
            end
            cpu_pkg::OPC_OP: begin
                ctrl.alu_op = alu_decode(funct3, inst[30]);
                ctrl.reg_we = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
    input  cpu_pkg::xlen_t    inst,
    input  cpu_pkg::imm_sel_e imm_sel,
    output cpu_pkg::xlen_t    imm
);

    always_comb begin
        case (imm_sel)
            cpu_pkg::IMM_I: imm = {{20{inst[31]}}, inst[31:20]};
            cpu_pkg::IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            // branch offsets are in half words
            cpu_pkg::IMM_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                   inst[11:8], 1'b0};
            cpu_pkg::IMM_U: imm = {inst[31:12], 12'd0};
            cpu_pkg::IMM_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                   inst[30:21], 1'b0};
            default:        imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we,
    input  cpu_pkg::reg_addr_t wa,
    input  cpu_pkg::reg_addr_t ra1,
    input  cpu_pkg::reg_addr_t ra2,
    input  cpu_pkg::xlen_t     wd,
    output cpu_pkg::xlen_t     rd1,
    output cpu_pkg::xlen_t     rd2
);

    // x0 has no storage
    cpu_pkg::xlen_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // write-through so D sees the W result in the same cycle
    assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

/* verilog/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
    input  cpu_pkg::xlen_t     x_pc,
    input  cpu_pkg::xlen_t     x_rs1_val,
    input  cpu_pkg::xlen_t     x_rs2_val,
    input  cpu_pkg::xlen_t     x_imm,
    input  cpu_pkg::reg_addr_t x_rs1,
    input  cpu_pkg::reg_addr_t x_rs2,
    input  cpu_pkg::ctrl_t     x_ctrl,
    input  logic               w_fwd_en,
    input  cpu_pkg::reg_addr_t w_rd,
    input  cpu_pkg::xlen_t     w_data,
    output cpu_pkg::xlen_t     alu_result,
    output cpu_pkg::xlen_t     store_data,
    output cpu_pkg::xlen_t     target,
    output logic               redirect
);

    logic            fwd_ok;
    cpu_pkg::xlen_t  rs1_val;
    cpu_pkg::xlen_t  rs2_val;
    cpu_pkg::xlen_t  op_a;
    cpu_pkg::xlen_t  op_b;
    logic [4:0]      shamt;
    logic            br_eq;
    logic            br_lt;
    logic            br_ltu;

    // W result replaces a stale operand
    assign fwd_ok  = w_fwd_en && (w_rd != 5'd0);
    assign rs1_val = (fwd_ok && w_rd == x_rs1) ? w_data : x_rs1_val;
    assign rs2_val = (fwd_ok && w_rd == x_rs2) ? w_data : x_rs2_val;

    assign op_a  = x_ctrl.a_is_pc ? x_pc : rs1_val;
    assign op_b  = x_ctrl.b_is_imm ? x_imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (x_ctrl.alu_op)
            cpu_pkg::ALU_SUB:    alu_result = op_a - op_b;
            cpu_pkg::ALU_SLL:    alu_result = op_a << shamt;
            cpu_pkg::ALU_SLT:    alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            cpu_pkg::ALU_SLTU:   alu_result = {31'd0, op_a < op_b};
            cpu_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            cpu_pkg::ALU_SRL:    alu_result = op_a >> shamt;
            cpu_pkg::ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
            cpu_pkg::ALU_OR:     alu_result = op_a | op_b;
            cpu_pkg::ALU_AND:    alu_result = op_a & op_b;
            cpu_pkg::ALU_COPY_B: alu_result = op_b;
            default:             alu_result = op_a + op_b;
        endcase
    end

    // branch comparator on the forwarded register values
    assign br_eq  = rs1_val == rs2_val;
    assign br_lt  = $signed(rs1_val) < $signed(rs2_val);
    assign br_ltu = rs1_val < rs2_val;

    always_comb begin
        case (x_ctrl.branch)
            cpu_pkg::BR_EQ:   redirect = br_eq;
            cpu_pkg::BR_NE:   redirect = !br_eq;
            cpu_pkg::BR_LT:   redirect = br_lt;
            cpu_pkg::BR_GE:   redirect = !br_lt;
            cpu_pkg::BR_LTU:  redirect = br_ltu;
            cpu_pkg::BR_GEU:  redirect = !br_ltu;
            cpu_pkg::BR_JUMP: redirect = 1'b1;
            default:          redirect = 1'b0;
        endcase
    end

    assign target     = x_ctrl.jalr ? {alu_result[31:1], 1'b0} : alu_result;
    assign store_data = rs2_val;

endmodule

`default_nettype wire

/* verilog/mem_align.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_align (
    input  logic                x_valid,
    input  cpu_pkg::ctrl_t      x_ctrl,
    input  cpu_pkg::xlen_t      addr,
    input  cpu_pkg::xlen_t      store_data,
    output mem_pkg::dmem_req_t  req,
    input  mem_pkg::size_e      w_size,
    input  logic                w_unsigned,
    input  logic [1:0]          w_offset,
    input  cpu_pkg::xlen_t      rdata,
    output cpu_pkg::xlen_t      load_data
);

    logic [3:0]      lanes;
    cpu_pkg::xlen_t  lane_data;
    cpu_pkg::xlen_t  shifted;

    // replicate the store value so every lane carries it
    always_comb begin
        case (x_ctrl.mem_size)
            mem_pkg::SIZE_BYTE: begin
                lanes     = 4'b0001 << addr[1:0];
                lane_data = {4{store_data[7:0]}};
            end
            mem_pkg::SIZE_HALF: begin
                lanes     = 4'b0011 << {addr[1], 1'b0};
                lane_data = {2{store_data[15:0]}};
            end
            default: begin
                lanes     = 4'b1111;
                lane_data = store_data;
            end
        endcase
    end

    always_comb begin
        req.addr  = addr[31:2];
        req.we    = (x_valid && x_ctrl.mem_write) ? lanes : 4'b0000;
        req.wdata = lane_data;
        req.re    = x_valid && x_ctrl.mem_read;
    end

    // addressed lane down to bit 0
    assign shifted = rdata >> {w_offset, 3'b000};

    always_comb begin
        case (w_size)
            mem_pkg::SIZE_BYTE: load_data = {{24{!w_unsigned && shifted[7]}}, shifted[7:0]};
            mem_pkg::SIZE_HALF: load_data = {{16{!w_unsigned && shifted[15]}}, shifted[15:0]};
            default:            load_data = rdata;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/sync_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module sync_ram #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic [3:0]            we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  cpu_pkg::xlen_t        wdata,
    input  logic                  re,
    input  logic [ADDR_WIDTH-1:0] raddr,
    output cpu_pkg::xlen_t        rdata
);

    cpu_pkg::xlen_t mem [0:(1 << ADDR_WIDTH) - 1];

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (we[b]) begin
                mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
        // read sees the old word on a same-address write
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

/* verilog/riscv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module riscv_core #(
    parameter logic [31:0] RESET_PC        = 32'h0000_0000,
    parameter int          IMEM_ADDR_WIDTH = 10,
    parameter int          DMEM_ADDR_WIDTH = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              imem_load_en,
    input  logic [31:0]       imem_load_addr,
    input  cpu_pkg::xlen_t    imem_load_data,
    output cpu_pkg::commit_t  commit
);

    typedef struct packed {
        cpu_pkg::xlen_t      pc;
        cpu_pkg::ctrl_t      ctrl;
        cpu_pkg::xlen_t      rs1_val;
        cpu_pkg::xlen_t      rs2_val;
        cpu_pkg::xlen_t      imm;
        cpu_pkg::reg_addr_t  rs1;
        cpu_pkg::reg_addr_t  rs2;
        cpu_pkg::reg_addr_t  rd;
    } x_stage_t;

    typedef struct packed {
        cpu_pkg::xlen_t      pc;
        cpu_pkg::ctrl_t      ctrl;
        cpu_pkg::xlen_t      alu;
        logic [1:0]          offset;
        cpu_pkg::reg_addr_t  rd;
    } w_stage_t;

    logic [31:0]         pc_d;
    logic [31:0]         pc_next;
    logic [31:0]         target_q;
    logic                redirect_q;
    logic                d_valid;
    logic                x_valid;
    logic                w_valid;
    cpu_pkg::xlen_t      inst;
    cpu_pkg::ctrl_t      d_ctrl;
    cpu_pkg::xlen_t      d_imm;
    cpu_pkg::xlen_t      d_rs1_val;
    cpu_pkg::xlen_t      d_rs2_val;
    x_stage_t            x_q;
    w_stage_t            w_q;
    cpu_pkg::xlen_t      alu_result;
    cpu_pkg::xlen_t      store_data;
    cpu_pkg::xlen_t      target;
    logic                branch_taken;
    logic                x_redirect;
    mem_pkg::dmem_req_t  dmem_req;
    cpu_pkg::xlen_t      dmem_rdata;
    cpu_pkg::xlen_t      load_data;
    cpu_pkg::xlen_t      wb_data;
    logic                w_we;

    // reset pc_d one word early so the first fetch lands on RESET_PC
    assign pc_next = redirect_q ? target_q : pc_d + 32'd4;

    // load address is a byte address
    sync_ram #(.ADDR_WIDTH(IMEM_ADDR_WIDTH)) imem (
        .clk   (clk),
        .we    ({4{imem_load_en}}),
        .waddr (imem_load_addr[IMEM_ADDR_WIDTH+1:2]),
        .wdata (imem_load_data),
        .re    (1'b1),
        .raddr (pc_next[IMEM_ADDR_WIDTH+1:2]),
        .rdata (inst)
    );

    controller ctrl_dec (
        .inst (inst),
        .ctrl (d_ctrl)
    );

    imm_gen imm_dec (
        .inst    (inst),
        .imm_sel (d_ctrl.imm_sel),
        .imm     (d_imm)
    );

    reg_file rf (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (w_we),
        .wa    (w_q.rd),
        .ra1   (inst[19:15]),
        .ra2   (inst[24:20]),
        .wd    (wb_data),
        .rd1   (d_rs1_val),
        .rd2   (d_rs2_val)
    );

    // taken redirect flushes D and X, the target is fetched next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_d       <= RESET_PC - 32'd4;
            redirect_q <= 1'b0;
            d_valid    <= 1'b0;
            x_valid    <= 1'b0;
            w_valid    <= 1'b0;
        end else begin
            pc_d       <= pc_next;
            redirect_q <= x_redirect;
            d_valid    <= !x_redirect;
            x_valid    <= d_valid && !x_redirect;
            w_valid    <= x_valid;
        end
    end

    always_ff @(posedge clk) begin
        target_q    <= target;
        x_q.pc      <= pc_d;
        x_q.ctrl    <= d_ctrl;
        x_q.rs1_val <= d_rs1_val;
        x_q.rs2_val <= d_rs2_val;
        x_q.imm     <= d_imm;
        x_q.rs1     <= inst[19:15];
        x_q.rs2     <= inst[24:20];
        x_q.rd      <= inst[11:7];
        w_q.pc      <= x_q.pc;
        w_q.ctrl    <= x_q.ctrl;
        w_q.alu     <= alu_result;
        w_q.offset  <= alu_result[1:0];
        w_q.rd      <= x_q.rd;
    end

    execute_unit exu (
        .x_pc       (x_q.pc),
        .x_rs1_val  (x_q.rs1_val),
        .x_rs2_val  (x_q.rs2_val),
        .x_imm      (x_q.imm),
        .x_rs1      (x_q.rs1),
        .x_rs2      (x_q.rs2),
        .x_ctrl     (x_q.ctrl),
        .w_fwd_en   (w_valid && w_q.ctrl.reg_we),
        .w_rd       (w_q.rd),
        .w_data     (wb_data),
        .alu_result (alu_result),
        .store_data (store_data),
        .target     (target),
        .redirect   (branch_taken)
    );

    assign x_redirect = x_valid && branch_taken;

    mem_align lsu (
        .x_valid    (x_valid),
        .x_ctrl     (x_q.ctrl),
        .addr       (alu_result),
        .store_data (store_data),
        .req        (dmem_req),
        .w_size     (w_q.ctrl.mem_size),
        .w_unsigned (w_q.ctrl.load_unsigned),
        .w_offset   (w_q.offset),
        .rdata      (dmem_rdata),
        .load_data  (load_data)
    );

    sync_ram #(.ADDR_WIDTH(DMEM_ADDR_WIDTH)) dmem (
        .clk   (clk),
        .we    (dmem_req.we),
        .waddr (dmem_req.addr[DMEM_ADDR_WIDTH-1:0]),
        .wdata (dmem_req.wdata),
        .re    (dmem_req.re),
        .raddr (dmem_req.addr[DMEM_ADDR_WIDTH-1:0]),
        .rdata (dmem_rdata)
    );

    always_comb begin
        case (w_q.ctrl.wb_sel)
            cpu_pkg::WB_LOAD: wb_data = load_data;
            cpu_pkg::WB_PC4:  wb_data = w_q.pc + 32'd4;
            default:          wb_data = w_q.alu;
        endcase
    end

    // writes to x0 retire without a write
    assign w_we = w_valid && w_q.ctrl.reg_we && (w_q.rd != 5'd0);

    // rd and data read as zero on non-writing commits
    always_comb begin
        commit.valid = w_valid;
        commit.pc    = w_q.pc;
        commit.rd    = w_we ? w_q.rd : 5'd0;
        commit.we    = w_we;
        commit.data  = w_we ? wb_data : '0;
    end

endmodule

`default_nettype wire

/* testbench/tb_riscv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_riscv_core;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int SETTLE_CYCLES = 20;
    localparam int MEM_WORDS     = 256;

    logic              clk;
    logic              rst_n;
    logic              imem_load_en;
    logic [31:0]       imem_load_addr;
    cpu_pkg::xlen_t    imem_load_data;
    cpu_pkg::commit_t  commit;

    logic [31:0]  test_mem [0:MEM_WORDS-1];
    int           prog_len;
    int           rec_count;
    int           commit_idx;
    bit           run_done;

    riscv_core #(
        .RESET_PC        (32'h0000_0000),
        .IMEM_ADDR_WIDTH (10),
        .DMEM_ADDR_WIDTH (10)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .commit         (commit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input int idx,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("Fail %s at commit %0d: got %h expected %h", name, idx, got, exp);
        $display("tests failed");
        $fatal(1, "simulation stopped on mismatch");
    endtask

    // record idx sits after the two counts and the program words
    function automatic cpu_pkg::commit_t expected_record(input int idx);
        int                base;
        cpu_pkg::commit_t  rec;
        base      = 2 + prog_len + 4 * idx;
        rec.valid = 1'b1;
        rec.pc    = test_mem[base];
        rec.rd    = test_mem[base + 1][4:0];
        rec.we    = test_mem[base + 2][0];
        rec.data  = test_mem[base + 3];
        return rec;
    endfunction

    task automatic check_commit(input cpu_pkg::commit_t got, input cpu_pkg::commit_t exp,
                                input int idx);
        if (got.pc !== exp.pc)
            report_mismatch("commit.pc", idx, got.pc, exp.pc);
        if (got.rd !== exp.rd)
            report_mismatch("commit.rd", idx, {27'd0, got.rd}, {27'd0, exp.rd});
        if (got.we !== exp.we)
            report_mismatch("commit.we", idx, {31'd0, got.we}, {31'd0, exp.we});
        if (got.data !== exp.data)
            report_mismatch("commit.data", idx, got.data, exp.data);
    endtask

    task automatic check_idle(input string phase);
        if (commit.valid !== 1'b0)
            abort_run({"commit.valid was not low ", phase});
    endtask

    initial begin
        rst_n          = 1'b0;
        imem_load_en   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        commit_idx     = 0;
        run_done       = 1'b0;
        $readmemh("testbench/core_tests.mem", test_mem);
        prog_len  = test_mem[0];
        rec_count = test_mem[1];
        if (2 + prog_len + 4 * rec_count > MEM_WORDS)
            abort_run("test data file is larger than the testbench buffer");

        // program goes in through the load port while reset is held
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            check_idle("while rst_n was low");
            imem_load_en   = 1'b1;
            imem_load_addr = i * 4;
            imem_load_data = test_mem[2 + i];
        end
        @(negedge clk);
        imem_load_en = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle("while rst_n was low");
        end
        rst_n = 1'b1;

        while (commit_idx < rec_count) begin
            @(negedge clk);
            if (commit.valid === 1'b1) begin
                check_commit(commit, expected_record(commit_idx), commit_idx);
                commit_idx++;
            end else if (commit.valid !== 1'b0) begin
                abort_run("commit.valid is unknown");
            end
        end

        // the core has no halt, so park it in reset after the last record
        rst_n = 1'b0;
        repeat (SETTLE_CYCLES) begin
            @(negedge clk);
            check_idle("after the last expected commit");
        end
        run_done = 1'b1;
        $display("all tests passed");
        $finish;
    end

    initial begin
        int limit;
        @(posedge rst_n);
        limit = 4 * rec_count + prog_len + 50;
        repeat (limit) @(posedge clk);
        if (!run_done)
            abort_run("commits stopped before all expected records were seen");
    end

endmodule

`default_nettype wire

/* testbench/core_tests.mem */
// word 0 program length, word 1 record count, then program words,
// then records of four words: pc rd we data
00000032 0000002A
00500093 FFD00113 002081B3 40208233 001122B3 00113333 40115393 00415413
00309493 FFF0C513 123455B7 00001617 00108013 6785E693 00D02023 00100703
002001A3 00300783 00304803 00201323 00601883 00605903 00001983 00205A03
00002A83 001A8B33 00108463 00100C13 00109463 00114463 00100C13 00115463
00116463 00117463 00100C13 00800CEF 00100C13 00CC8D67 00100C13 007C0D93
00208463 00209463 00100C13 0020D463 00100C13 0020C463 0020E463 00100C13
0020F463 001D8E13
00000000 01 1 00000005  00000004 02 1 FFFFFFFD  00000008 03 1 00000002
0000000C 04 1 00000008  00000010 05 1 00000001  00000014 06 1 00000000
00000018 07 1 FFFFFFFE  0000001C 08 1 0FFFFFFF  00000020 09 1 00000028
00000024 0A 1 FFFFFFFA  00000028 0B 1 12345000  0000002C 0C 1 0000102C
00000030 00 0 00000000  00000034 0D 1 12345678  00000038 00 0 00000000
0000003C 0E 1 00000056  00000040 00 0 00000000  00000044 0F 1 FFFFFFFD
00000048 10 1 000000FD  0000004C 00 0 00000000  00000050 11 1 FFFFFFFD
00000054 12 1 0000FFFD  00000058 13 1 00005678  0000005C 14 1 0000FD34
00000060 15 1 FD345678  00000064 16 1 FD34567D  00000068 00 0 00000000
00000070 00 0 00000000  00000074 00 0 00000000  0000007C 00 0 00000000
00000080 00 0 00000000  00000084 00 0 00000000  0000008C 19 1 00000090
00000094 1A 1 00000098  0000009C 1B 1 00000007  000000A0 00 0 00000000
000000A4 00 0 00000000  000000AC 00 0 00000000  000000B4 00 0 00000000
000000B8 00 0 00000000  000000C0 00 0 00000000  000000C4 1C 1 00000008

/* filelist.f */
verilog/mem_pkg.sv
verilog/cpu_pkg.sv
verilog/controller.sv
verilog/imm_gen.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/mem_align.sv
verilog/sync_ram.sv
verilog/riscv_core.sv
testbench/tb_riscv_core.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing --top-module tb_riscv_core -f filelist.f -o tb_sim && \
./obj_dir/tb_sim | tee /dev/stderr | grep -q "all tests passed" && \
echo "simulation PASSED" || { echo "simulation FAILED"; exit 1; }
